// ==== source/imgproc_cfg.svh ====
`ifndef IMGPROC_CFG_SVH
`define IMGPROC_CFG_SVH

// Frame geometry in pixels, up to 2047 each
`define IMAGE_W 16
`define IMAGE_H 12

// Width of an x or y coordinate
`define COORD_W 11

// Message FIFO size in 32-bit words
`define MSG_FIFO_DEPTH 64

// Video frames between two messages
`define MSG_INTERVAL 6

// Words per message: min and max for red, green, blue
`define MSG_WORDS 6

// Register map of the memory-mapped port
`define ADDR_STATUS 3'd0
`define ADDR_MSG 3'd1
`define ADDR_ID 3'd2

// Fixed value of the ID register
`define ID_WORD 32'h1234EEE2

`endif

// ==== source/imgproc_pkg.sv ====
`include "imgproc_cfg.svh"

package imgproc_pkg;

	// Plain vector types
	typedef logic [`COORD_W-1:0] coord_t;
	typedef logic [7:0] channel_t;
	typedef logic [31:0] msg_word_t;
	typedef logic [2:0] addr_t;

	// One RGB pixel, red in the top byte
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} pixel_t;

	// Contents of one stream stage
	typedef struct packed {
		pixel_t pixel;
		logic sop;
		logic eop;
	} beat_t;

	// Pixel class, one-hot in RGB order
	typedef enum logic [2:0] {
		NONE = 3'b000,
		RED = 3'b100,
		GREEN = 3'b010,
		BLUE = 3'b001
	} colour_e;

	// Per-beat record from the pipeline to the tracker
	typedef struct packed {
		logic valid;
		logic sop;
		logic eop;
		logic video;
		coord_t x;
		coord_t y;
		colour_e colour;
	} track_t;

	typedef struct packed {
		coord_t x_min;
		coord_t x_max;
		coord_t y_min;
		coord_t y_max;
	} box_t;

	typedef struct packed {
		box_t red;
		box_t green;
		box_t blue;
	} box_set_t;

	typedef enum logic [0:0] {
		IDLE = 1'b0,
		EMIT = 1'b1
	} msg_state_e;

endpackage

// ==== source/pixel_pipe.sv ====
`timescale 1ns/10ps
`include "imgproc_cfg.svh"

module pixel_pipe (
	input logic clk,
	input logic reset_n,
	input imgproc_pkg::beat_t sink,
	input logic sink_valid,
	output logic sink_ready,
	output imgproc_pkg::beat_t source,
	output logic source_valid,
	input logic source_ready,
	input logic mode,
	output imgproc_pkg::track_t track
);
	import imgproc_pkg::*;

	localparam coord_t X_LAST = coord_t'(`IMAGE_W - 1);

	// Stage 0 is the input register, stage 1 drives the source
	beat_t stage_q [2];
	beat_t stage_d [2];
	logic [1:0] stage_valid;
	logic [1:0] stage_valid_d;
	logic [1:0] stage_ready;
	logic [1:0] next_ready;

	beat_t in_beat;
	beat_t out_beat;
	logic transfer;

	coord_t x_q;
	coord_t y_q;
	logic video_q;
	logic video_cur;
	colour_e colour;
	pixel_t highlight;
	channel_t grey;

	//////////////////////////////////////////////////////////////////////
	// Stream registers
	//////////////////////////////////////////////////////////////////////

	// A stage accepts when empty or when it empties this cycle
	assign next_ready = {source_ready, stage_ready[1]};
	assign stage_ready = ~stage_valid | next_ready;
	assign stage_valid_d = {stage_valid[0], sink_valid};
	assign stage_d[0] = sink;
	assign stage_d[1] = out_beat;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			stage_valid <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (stage_ready[i])
					stage_valid[i] <= stage_valid_d[i];
			end
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (stage_ready[i] && stage_valid_d[i])
				stage_q[i] <= stage_d[i];
		end
	end

	assign sink_ready = stage_ready[0];
	assign source = stage_q[1];
	assign source_valid = stage_valid[1];

	assign in_beat = stage_q[0];
	// Input stage hands its beat to the output stage
	assign transfer = stage_valid[0] & stage_ready[1];

	//////////////////////////////////////////////////////////////////////
	// Coordinates and packet type
	//////////////////////////////////////////////////////////////////////

	// Packet type comes straight from the descriptor while sop sits here
	assign video_cur = in_beat.sop ? (in_beat.pixel.blue[3:0] == 4'h0) : video_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x_q <= '0;
			y_q <= '0;
			video_q <= 1'b0;
		end else if (transfer) begin
			if (in_beat.sop) begin
				x_q <= '0;
				y_q <= '0;
				video_q <= video_cur;
			end else if (x_q == X_LAST) begin
				// End of line
				x_q <= '0;
				y_q <= y_q + 1'b1;
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	// Top-bit classification, one channel high and the others low
	always_comb begin
		case ({in_beat.pixel.red[7], in_beat.pixel.green[7], in_beat.pixel.blue[7]})
			3'b100: colour = RED;
			3'b010: colour = GREEN;
			3'b001: colour = BLUE;
			default: colour = NONE;
		endcase
	end

	// Grey = green/2 + red/4 + blue/4, tops out at 253
	assign grey = channel_t'(in_beat.pixel.green[7:1])
		+ channel_t'(in_beat.pixel.red[7:2])
		+ channel_t'(in_beat.pixel.blue[7:2]);

	always_comb begin
		case (colour)
			RED: highlight = '{red: 8'hff, green: 8'h00, blue: 8'h00};
			GREEN: highlight = '{red: 8'h00, green: 8'hff, blue: 8'h00};
			BLUE: highlight = '{red: 8'h00, green: 8'h00, blue: 8'hff};
			default: highlight = '{red: grey, green: grey, blue: grey};
		endcase
	end

	// Descriptor beat and non-video packets pass untouched
	always_comb begin
		out_beat = in_beat;
		if (mode && video_cur && !in_beat.sop)
			out_beat.pixel = highlight;
	end

	assign track = '{
		valid: transfer,
		sop: in_beat.sop,
		eop: in_beat.eop,
		video: video_cur,
		x: x_q,
		y: y_q,
		colour: colour
	};

endmodule

// ==== source/box_tracker.sv ====
`timescale 1ns/10ps
`include "imgproc_cfg.svh"

module box_tracker (
	input logic clk,
	input logic reset_n,
	input imgproc_pkg::track_t track,
	output logic frame_done,
	output imgproc_pkg::box_set_t boxes
);
	import imgproc_pkg::*;

	// Empty-box values, min at the far corner and max at the origin
	localparam coord_t X_LAST = coord_t'(`IMAGE_W - 1);
	localparam coord_t Y_LAST = coord_t'(`IMAGE_H - 1);

	// Index 0 red, 1 green, 2 blue
	box_t work_q [3];
	box_t work_d [3];
	logic [2:0] hit;
	logic pixel_valid;
	logic frame_end;

	// Only data beats count as pixels
	assign pixel_valid = track.valid & ~track.sop;
	assign hit[0] = pixel_valid & (track.colour == RED);
	assign hit[1] = pixel_valid & (track.colour == GREEN);
	assign hit[2] = pixel_valid & (track.colour == BLUE);

	// Last beat of a video packet closes the frame
	assign frame_end = track.valid & track.eop & track.video;

	//////////////////////////////////////////////////////////////////////
	// Working bounds
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			work_d[i] = work_q[i];
			if (track.valid && track.sop) begin
				// New packet, start from an empty box
				work_d[i].x_min = X_LAST;
				work_d[i].x_max = '0;
				work_d[i].y_min = Y_LAST;
				work_d[i].y_max = '0;
			end else if (hit[i]) begin
				if (track.x < work_q[i].x_min)
					work_d[i].x_min = track.x;
				if (track.x > work_q[i].x_max)
					work_d[i].x_max = track.x;
				if (track.y < work_q[i].y_min)
					work_d[i].y_min = track.y;
				// Raster order, so the latest hit is the lowest row
				work_d[i].y_max = track.y;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (track.valid) begin
			for (int i = 0; i < 3; i++)
				work_q[i] <= work_d[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// End of frame
	//////////////////////////////////////////////////////////////////////

	// Latch includes the eop pixel itself
	always_ff @(posedge clk) begin
		if (frame_end) begin
			boxes.red <= work_d[0];
			boxes.green <= work_d[1];
			boxes.blue <= work_d[2];
		end
	end

	// One-cycle strobe alongside the new boxes
	always_ff @(posedge clk) begin
		if (!reset_n)
			frame_done <= 1'b0;
		else
			frame_done <= frame_end;
	end

endmodule

// ==== source/msg_writer.sv ====
`timescale 1ns/10ps
`include "imgproc_cfg.svh"

module msg_writer (
	input logic clk,
	input logic reset_n,
	input logic frame_done,
	input imgproc_pkg::box_set_t boxes,
	input logic [7:0] fifo_used,
	output logic wr_en,
	output imgproc_pkg::msg_word_t wr_data
);
	import imgproc_pkg::*;

	localparam logic [7:0] RELOAD = 8'(`MSG_INTERVAL - 1);
	localparam logic [2:0] LAST_WORD = 3'(`MSG_WORDS - 1);

	msg_state_e state;
	logic [7:0] frame_cnt;
	logic [2:0] word_idx;
	logic [8:0] fifo_free;
	logic room;

	box_t sel_box;
	colour_e sel_code;
	coord_t word_x;
	coord_t word_y;
	logic is_max;

	// Room for a whole message
	assign fifo_free = 9'(`MSG_FIFO_DEPTH) - {1'b0, fifo_used};
	assign room = fifo_free >= 9'(`MSG_WORDS);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			frame_cnt <= '0;
			word_idx <= '0;
		end else begin
			if (state == EMIT) begin
				word_idx <= word_idx + 1'b1;
				if (word_idx == LAST_WORD)
					state <= IDLE;
			end
			if (frame_done) begin
				if (frame_cnt != '0) begin
					frame_cnt <= frame_cnt - 1'b1;
				end else if (room) begin
					frame_cnt <= RELOAD;
					state <= EMIT;
					word_idx <= '0;
				end
				// Counter at zero and FIFO too full: retry next frame
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Word format
	//////////////////////////////////////////////////////////////////////

	// Pairs of words per colour, min first
	always_comb begin
		case (word_idx[2:1])
			2'd0: begin
				sel_box = boxes.red;
				sel_code = RED;
			end
			2'd1: begin
				sel_box = boxes.green;
				sel_code = GREEN;
			end
			default: begin
				sel_box = boxes.blue;
				sel_code = BLUE;
			end
		endcase
	end

	assign is_max = word_idx[0];
	assign word_x = is_max ? sel_box.x_max : sel_box.x_min;
	assign word_y = is_max ? sel_box.y_max : sel_box.y_min;

	// Code 31:29, max flag 28, x 26:16, y 10:0
	assign wr_data = {sel_code, is_max, 1'b0, word_x, 5'b0, word_y};
	assign wr_en = (state == EMIT);

endmodule

// ==== source/msg_fifo.sv ====
`timescale 1ns/10ps
`include "imgproc_cfg.svh"

module msg_fifo (
	input logic clk,
	input logic reset_n,
	input logic flush,
	input logic wr_en,
	input imgproc_pkg::msg_word_t wr_data,
	input logic rd_en,
	output imgproc_pkg::msg_word_t head,
	output logic [7:0] used,
	output logic empty
);
	import imgproc_pkg::*;

	localparam int PTR_W = $clog2(`MSG_FIFO_DEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`MSG_FIFO_DEPTH - 1);

	msg_word_t mem [`MSG_FIFO_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [7:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count == 8'(`MSG_FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr_en & ~full;
	assign do_rd = rd_en & ~empty;

	// Pointers and count
	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// Show-ahead, oldest word always on head
	assign head = mem[rd_ptr];
	assign used = count;

endmodule

// ==== source/mm_regs.sv ====
`timescale 1ns/10ps
`include "imgproc_cfg.svh"

module mm_regs (
	input logic clk,
	input logic reset_n,
	input logic s_chipselect,
	input logic s_read,
	input logic s_write,
	input imgproc_pkg::addr_t s_address,
	input imgproc_pkg::msg_word_t s_writedata,
	output imgproc_pkg::msg_word_t s_readdata,
	input imgproc_pkg::msg_word_t fifo_head,
	input logic [7:0] fifo_used,
	input logic fifo_empty,
	output logic rd_en,
	output logic flush
);

	// Status bits
	// 15:8 FIFO word count, read only
	// 7:0 scratch byte, bit 4 of a write also flushes
	logic [7:0] scratch;
	logic read_d;
	logic rd_strobe;
	logic wr_strobe;

	assign rd_strobe = s_chipselect & s_read;
	assign wr_strobe = s_chipselect & s_write;

	//////////////////////////////////////////////////////////////////////
	// Writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n)
			scratch <= '0;
		else if (wr_strobe && s_address == `ADDR_STATUS)
			scratch <= s_writedata[7:0];
	end

	assign flush = wr_strobe & (s_address == `ADDR_STATUS) & s_writedata[4];

	//////////////////////////////////////////////////////////////////////
	// Reads
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= rd_strobe;
			if (rd_strobe) begin
				case (s_address)
					`ADDR_STATUS: s_readdata <= {16'b0, fifo_used, scratch};
					`ADDR_MSG: s_readdata <= fifo_head;
					`ADDR_ID: s_readdata <= `ID_WORD;
					default: s_readdata <= '0;
				endcase
			end
		end
	end

	// Pop on the rising edge of the read only, so a held read pops once
	assign rd_en = rd_strobe & ~read_d & ~fifo_empty & (s_address == `ADDR_MSG);

endmodule

// ==== source/imgproc_top.sv ====
`timescale 1ns/10ps

module imgproc_top (
	input logic clk,
	input logic reset_n,
	// Stream sink
	input logic [23:0] sink_data,
	input logic sink_valid,
	input logic sink_sop,
	input logic sink_eop,
	output logic sink_ready,
	// Stream source
	output logic [23:0] source_data,
	output logic source_valid,
	output logic source_sop,
	output logic source_eop,
	input logic source_ready,
	// Highlight enable
	input logic mode,
	// CPU register port
	input logic s_chipselect,
	input logic s_read,
	input logic s_write,
	input imgproc_pkg::addr_t s_address,
	input imgproc_pkg::msg_word_t s_writedata,
	output imgproc_pkg::msg_word_t s_readdata
);
	import imgproc_pkg::*;

	beat_t sink_beat;
	beat_t source_beat;
	track_t track;
	logic frame_done;
	box_set_t boxes;
	logic wr_en;
	msg_word_t wr_data;
	logic rd_en;
	logic flush;
	msg_word_t fifo_head;
	logic [7:0] fifo_used;
	logic fifo_empty;

	// Flat stream ports to beat records
	assign sink_beat = '{pixel: sink_data, sop: sink_sop, eop: sink_eop};
	assign source_data = source_beat.pixel;
	assign source_sop = source_beat.sop;
	assign source_eop = source_beat.eop;

	//////////////////////////////////////////////////////////////////////
	// Video path and tracking
	//////////////////////////////////////////////////////////////////////

	pixel_pipe u_pipe (
		.clk(clk),
		.reset_n(reset_n),
		.sink(sink_beat),
		.sink_valid(sink_valid),
		.sink_ready(sink_ready),
		.source(source_beat),
		.source_valid(source_valid),
		.source_ready(source_ready),
		.mode(mode),
		.track(track)
	);

	box_tracker u_tracker (
		.clk(clk),
		.reset_n(reset_n),
		.track(track),
		.frame_done(frame_done),
		.boxes(boxes)
	);

	// Messages: writer fills the FIFO, register port drains it
	msg_writer u_writer (
		.clk(clk),
		.reset_n(reset_n),
		.frame_done(frame_done),
		.boxes(boxes),
		.fifo_used(fifo_used),
		.wr_en(wr_en),
		.wr_data(wr_data)
	);

	msg_fifo u_fifo (
		.clk(clk),
		.reset_n(reset_n),
		.flush(flush),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.head(fifo_head),
		.used(fifo_used),
		.empty(fifo_empty)
	);

	mm_regs u_regs (
		.clk(clk),
		.reset_n(reset_n),
		.s_chipselect(s_chipselect),
		.s_read(s_read),
		.s_write(s_write),
		.s_address(s_address),
		.s_writedata(s_writedata),
		.s_readdata(s_readdata),
		.fifo_head(fifo_head),
		.fifo_used(fifo_used),
		.fifo_empty(fifo_empty),
		.rd_en(rd_en),
		.flush(flush)
	);

endmodule

// ==== sim/tb_imgproc.sv ====
`timescale 1ns/10ps
`include "imgproc_cfg.svh"

module tb_imgproc;
	import imgproc_pkg::*;

	localparam int CLK_PERIOD = 40;
	// Outputs are read this long after the falling edge
	localparam int SAMPLE_DELAY = 10;
	localparam int SEED = 85048;
	localparam int MAX_FRAMES = 32;
	localparam int FRAME_WORDS = 9;
	localparam int NV_BEATS = 5;
	localparam int PIXELS = `IMAGE_W * `IMAGE_H;

	logic clk;
	logic reset_n;
	logic [23:0] sink_data;
	logic sink_valid;
	logic sink_sop;
	logic sink_eop;
	logic sink_ready;
	logic [23:0] source_data;
	logic source_valid;
	logic source_sop;
	logic source_eop;
	logic source_ready;
	logic mode;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	addr_t s_address;
	msg_word_t s_writedata;
	msg_word_t s_readdata;

	// Frame count in word 0 and then FRAME_WORDS per frame
	logic [31:0] frame_mem [1 + MAX_FRAMES * FRAME_WORDS];
	int n_frames;
	int timeout_limit;
	int cycle_count;
	int checks;
	int stream_errors;
	int reg_errors;
	int other_errors;

	// Reference model state
	beat_t exp_beats[$];
	pixel_t image [`IMAGE_H][`IMAGE_W];
	box_t exp_boxes [3];
	msg_word_t exp_msg [`MSG_WORDS];
	int exp_used;
	int frame_cnt_model;
	logic [7:0] scratch_model;

	imgproc_top u_dut (
		.clk(clk),
		.reset_n(reset_n),
		.sink_data(sink_data),
		.sink_valid(sink_valid),
		.sink_sop(sink_sop),
		.sink_eop(sink_eop),
		.sink_ready(sink_ready),
		.source_data(source_data),
		.source_valid(source_valid),
		.source_sop(source_sop),
		.source_eop(source_eop),
		.source_ready(source_ready),
		.mode(mode),
		.s_chipselect(s_chipselect),
		.s_read(s_read),
		.s_write(s_write),
		.s_address(s_address),
		.s_writedata(s_writedata),
		.s_readdata(s_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////////////////////////

	// Class needs one top bit set and the other two clear
	function automatic colour_e classify(input pixel_t p);
		if (p.red[7] && !p.green[7] && !p.blue[7])
			return RED;
		if (!p.red[7] && p.green[7] && !p.blue[7])
			return GREEN;
		if (!p.red[7] && !p.green[7] && p.blue[7])
			return BLUE;
		return NONE;
	endfunction

	function automatic pixel_t highlight_of(input pixel_t p);
		pixel_t h;
		channel_t g;
		g = (p.green >> 1) + (p.red >> 2) + (p.blue >> 2);
		case (classify(p))
			RED: h = {8'hff, 8'h00, 8'h00};
			GREEN: h = {8'h00, 8'hff, 8'h00};
			BLUE: h = {8'h00, 8'h00, 8'hff};
			default: h = {g, g, g};
		endcase
		return h;
	endfunction

	function automatic int colour_index(input colour_e c);
		case (c)
			RED: return 0;
			GREEN: return 1;
			default: return 2;
		endcase
	endfunction

	// Rect word holds x0 y0 x1 y1 or all ones for none
	function automatic bit rect_covers(input logic [31:0] rect, input int x, input int y);
		if (rect == 32'hFFFFFFFF)
			return 1'b0;
		return x >= int'(rect[31:24]) && x <= int'(rect[15:8])
			&& y >= int'(rect[23:16]) && y <= int'(rect[7:0]);
	endfunction

	// Code 31:29, max flag 28, x 26:16, y 10:0
	function automatic msg_word_t box_word(input colour_e code, input bit is_max, input box_t b);
		msg_word_t w;
		w = '0;
		w[31:29] = code;
		w[28] = is_max;
		w[26:16] = is_max ? b.x_max : b.x_min;
		w[10:0] = is_max ? b.y_max : b.y_min;
		return w;
	endfunction

	function automatic msg_word_t status_word();
		return {16'h0, 8'(exp_used), scratch_model};
	endfunction

	// Paint background and rectangles, then derive bounds and message
	task automatic build_frame(input int base);
		colour_e c;
		colour_e code;
		coord_t cx;
		coord_t cy;
		int k;
		for (int i = 0; i < 3; i++) begin
			exp_boxes[i].x_min = coord_t'(`IMAGE_W - 1);
			exp_boxes[i].x_max = '0;
			exp_boxes[i].y_min = coord_t'(`IMAGE_H - 1);
			exp_boxes[i].y_max = '0;
		end
		for (int y = 0; y < `IMAGE_H; y++) begin
			for (int x = 0; x < `IMAGE_W; x++) begin
				image[y][x] = frame_mem[base + 2][23:0];
				// Later colours paint over earlier ones
				for (int i = 0; i < 3; i++) begin
					if (rect_covers(frame_mem[base + 4 + 2 * i], x, y))
						image[y][x] = frame_mem[base + 3 + 2 * i][23:0];
				end
				c = classify(image[y][x]);
				if (c != NONE) begin
					k = colour_index(c);
					cx = coord_t'(x);
					cy = coord_t'(y);
					if (cx < exp_boxes[k].x_min)
						exp_boxes[k].x_min = cx;
					if (cx > exp_boxes[k].x_max)
						exp_boxes[k].x_max = cx;
					if (cy < exp_boxes[k].y_min)
						exp_boxes[k].y_min = cy;
					if (cy > exp_boxes[k].y_max)
						exp_boxes[k].y_max = cy;
				end
			end
		end
		for (int i = 0; i < 3; i++) begin
			code = (i == 0) ? RED : (i == 1) ? GREEN : BLUE;
			exp_msg[2 * i] = box_word(code, 1'b0, exp_boxes[i]);
			exp_msg[2 * i + 1] = box_word(code, 1'b1, exp_boxes[i]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stream driver and monitor
	//////////////////////////////////////////////////////////////////////

	// Random idle cycles before the beat, which is held until sink_ready
	task automatic send_beat(input beat_t b);
		@(negedge clk);
		while ($urandom % 4 == 0) begin
			sink_valid = 1'b0;
			@(negedge clk);
		end
		sink_data = b.pixel;
		sink_sop = b.sop;
		sink_eop = b.eop;
		sink_valid = 1'b1;
		#(SAMPLE_DELAY);
		while (!sink_ready) begin
			@(negedge clk);
			#(SAMPLE_DELAY);
		end
	endtask

	task automatic send_video(input bit hl);
		beat_t b;
		beat_t e;
		// Blue low nibble zero marks a video descriptor
		b.pixel = 24'h123450;
		b.sop = 1'b1;
		b.eop = 1'b0;
		exp_beats.push_back(b);
		send_beat(b);
		for (int y = 0; y < `IMAGE_H; y++) begin
			for (int x = 0; x < `IMAGE_W; x++) begin
				b.pixel = image[y][x];
				b.sop = 1'b0;
				b.eop = (y == `IMAGE_H - 1) && (x == `IMAGE_W - 1);
				e = b;
				if (hl)
					e.pixel = highlight_of(b.pixel);
				exp_beats.push_back(e);
				send_beat(b);
			end
		end
	endtask

	// Non-video packets always pass untouched
	task automatic send_other(input int base);
		beat_t b;
		b.pixel = 24'h00000F;
		b.sop = 1'b1;
		b.eop = 1'b0;
		exp_beats.push_back(b);
		send_beat(b);
		for (int i = 0; i < NV_BEATS; i++) begin
			b.pixel = frame_mem[base + 2][23:0] + 24'(i);
			b.sop = 1'b0;
			b.eop = (i == NV_BEATS - 1);
			exp_beats.push_back(b);
			send_beat(b);
		end
	endtask

	initial begin
		source_ready = 1'b0;
		forever begin
			@(negedge clk);
			source_ready = ($urandom % 4) != 0;
		end
	end

	initial begin
		beat_t got;
		beat_t exp;
		forever begin
			@(negedge clk);
			#(SAMPLE_DELAY);
			if (reset_n && source_valid && source_ready) begin
				got.pixel = source_data;
				got.sop = source_sop;
				got.eop = source_eop;
				checks++;
				assert (exp_beats.size() > 0) else begin
					stream_errors++;
					$display("[ERROR] time %0t: beat %h on the source with none expected",
						$time, got);
				end
				if (exp_beats.size() > 0) begin
					exp = exp_beats.pop_front();
					assert (got == exp) else begin
						stream_errors++;
						$display("[ERROR] time %0t: source beat %h, expected %h",
							$time, got, exp);
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Register port
	//////////////////////////////////////////////////////////////////////

	// Read data arrives one cycle after the strobe
	task automatic reg_read(input addr_t addr, output msg_word_t data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_read = 1'b0;
		data = s_readdata;
	endtask

	task automatic reg_write(input addr_t addr, input msg_word_t data);
		@(negedge clk);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(negedge clk);
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	task automatic check_reg(input addr_t addr, input msg_word_t exp, input string what);
		msg_word_t got;
		reg_read(addr, got);
		checks++;
		assert (got == exp) else begin
			reg_errors++;
			$display("[ERROR] time %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame sequence
	//////////////////////////////////////////////////////////////////////

	task automatic run_frame(input int f);
		int base;
		bit video;
		bit emit;
		int n_read;
		base = 1 + f * FRAME_WORDS;
		video = frame_mem[base][0];
		emit = 1'b0;
		@(negedge clk);
		mode = frame_mem[base + 1][0];
		if (video) begin
			build_frame(base);
			send_video(frame_mem[base + 1][0]);
		end else begin
			send_other(base);
		end
		@(negedge clk);
		sink_valid = 1'b0;
		// Wait until every expected beat has left the source
		while (exp_beats.size() != 0)
			@(negedge clk);
		// frame_done follows eop by a cycle and six writes follow it
		repeat (10) @(negedge clk);
		if (video) begin
			if (frame_cnt_model != 0) begin
				frame_cnt_model--;
			end else if (`MSG_FIFO_DEPTH - exp_used >= `MSG_WORDS) begin
				frame_cnt_model = `MSG_INTERVAL - 1;
				exp_used += `MSG_WORDS;
				emit = 1'b1;
			end
		end
		$display("Packet %0d: video %0d, mode %0d, message %0d", f, video, mode, emit);
		check_reg(`ADDR_STATUS, status_word(), "status");
		if (emit) begin
			// Last message is only partly read and the flush clears the rest
			n_read = (f == n_frames - 1) ? 2 : `MSG_WORDS;
			for (int k = 0; k < n_read; k++)
				check_reg(`ADDR_MSG, exp_msg[k], "message word");
			exp_used -= n_read;
		end
	endtask

	task automatic print_summary();
		$display("Checks: %0d, stream errors: %0d, register errors: %0d, other errors: %0d",
			checks, stream_errors, reg_errors, other_errors);
	endtask

	// Run limit scaled by the number of frames
	initial begin
		cycle_count = 0;
		wait (timeout_limit > 0);
		while (cycle_count < timeout_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
		print_summary();
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		reset_n = 1'b0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		mode = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_address = '0;
		s_writedata = '0;
		checks = 0;
		stream_errors = 0;
		reg_errors = 0;
		other_errors = 0;
		exp_used = 0;
		frame_cnt_model = 0;
		scratch_model = 8'h00;

		$readmemh("sim/tb_frames_input.txt", frame_mem);
		n_frames = int'(frame_mem[0]);
		assert (n_frames > 0 && n_frames <= MAX_FRAMES) else begin
			other_errors++;
			$display("Frame file unusable: it gives %0d frames", n_frames);
		end
		if (n_frames > MAX_FRAMES || n_frames < 0)
			n_frames = 0;
		timeout_limit = n_frames * (PIXELS + 2) * 4 + 2000;

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		check_reg(`ADDR_STATUS, status_word(), "status after reset");
		for (int f = 0; f < n_frames; f++)
			run_frame(f);

		// Flush leftover words and check the scratch byte
		check_reg(`ADDR_STATUS, status_word(), "status before flush");
		reg_write(`ADDR_STATUS, 32'h0000_0015);
		scratch_model = 8'h15;
		exp_used = 0;
		check_reg(`ADDR_STATUS, status_word(), "status after flush");
		reg_write(`ADDR_STATUS, 32'h0000_00A2);
		scratch_model = 8'hA2;
		check_reg(`ADDR_STATUS, status_word(), "scratch byte");
		check_reg(`ADDR_ID, `ID_WORD, "ID register");

		print_summary();
		if (stream_errors + reg_errors + other_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+source
source/imgproc_pkg.sv
source/pixel_pipe.sv
source/box_tracker.sv
source/msg_writer.sv
source/msg_fifo.sv
source/mm_regs.sv
source/imgproc_top.sv
sim/tb_imgproc.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing --assert -j 0
TOP := tb_imgproc
FILELIST := src.f
OBJ_DIR := obj_dir

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard source/*.svh)

.PHONY: all run clean

all: run

# Rebuild only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_frames_input.txt ====
// First word: number of frames, then one frame per line
// type(1=video) mode background red_pix red_rect green_pix green_rect blue_pix blue_rect
10
1 0 303030 C02030 01020508 109030 0A000F03 2040C8 03070B0B
0 0 123456 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
1 1 808080 C02030 00000000 109030 FFFFFFFF 2040C8 0F0B0F0B
1 1 7F7F7F FF0000 04040707 00FF00 05060A08 0000FF FFFFFFFF
0 1 ABCDEF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
1 0 000000 C02030 FFFFFFFF 109030 FFFFFFFF 2040C8 FFFFFFFF
1 1 A0A000 C00000 00000F00 00C000 000B0F0B 0000C0 0F000F0B
1 0 202020 C02030 02020D09 109030 06030906 2040C8 FFFFFFFF
1 1 303030 E01010 0C010E02 10E010 01080409 1010E0 07050806
0 0 000001 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
1 1 445566 C02030 00050F05 109030 07000700 2040C8 FFFFFFFF
1 1 102030 C02030 0B090B09 E0E010 00000705 2040C8 08080A0A
1 0 3C3C3C 900000 01010101 009000 0E0A0E0A 000090 05050909
1 1 606060 C02030 00000F0B 109030 FFFFFFFF 2040C8 FFFFFFFF
1 0 111111 C02030 0A0A0B0B 109030 00000101 2040C8 05000500
1 1 505050 C02030 02010C0A 109030 0D020E09 2040C8 04030605
